// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --timescale 1ns/1ps -j 0
TOP = tb_correlator
FILELIST = tb.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

// ==== design/corr_cfg_pkg.sv ====
// Correlator geometry and data types
`default_nettype none

package corr_cfg_pkg;

	localparam int num_lines = 4;
	localparam int num_lags = 2; // Lag 0 and lag 1

	// Every unordered pair of distinct lines
	localparam int num_baselines = num_lines * (num_lines - 1) / 2;

	localparam int num_counts = num_lines * num_lags + num_baselines * num_lags;
	localparam int count_w = 24;

	// One registered sample of all lines
	typedef struct packed {
		logic valid;
		logic [num_lines-1:0] bits;
	} sample_t;

	// Counts of one frame, index 0 in the low bits
	// Autocorrelations by line then lag, then cross pairs (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
	typedef struct packed {
		logic [num_counts-1:0][count_w-1:0] counts;
	} frame_t;

endpackage

`default_nettype wire

// ==== design/corr_pkt_pkg.sv ====
// Output word format
`default_nettype none

package corr_pkt_pkg;

	localparam int word_w = 32;
	localparam int seq_w = 7;
	localparam int index_w = 7;
	localparam int value_w = 24;

	// Kind bit, the MSB of every word
	localparam logic word_kind_header = 1'b1;
	localparam logic word_kind_count = 1'b0;

	// First word of each frame
	typedef struct packed {
		logic kind;
		logic [seq_w-1:0] seq;
		logic [7:0] line_count;
		logic [7:0] lag_count;
		logic [7:0] resolution;
	} header_t;

	// One count of a frame
	typedef struct packed {
		logic kind;
		logic [index_w-1:0] index;
		logic [value_w-1:0] value;
	} count_word_t;

	// Kind sits at the MSB in both views so either one can be used to tell them apart
	typedef union packed {
		header_t header;
		count_word_t count;
	} pkt_word_u;

endpackage

`default_nettype wire

// ==== design/correlator_top.sv ====
// Pulse line correlator top
`default_nettype none

module correlator_top #(
	parameter int NUM_CREDITS = 4,
	parameter int INTEG_W = 16
) (
	input logic pllclk,
	input logic rst_n,
	input logic [corr_cfg_pkg::num_lines-1:0] lines,
	input logic [corr_cfg_pkg::num_lines-1:0] invert,
	input logic [INTEG_W-1:0] integ_len,
	input logic start,
	input logic credit_return,
	output corr_pkt_pkg::pkt_word_u out_word,
	output logic out_valid,
	output logic busy
);

	corr_cfg_pkg::sample_t sample;
	corr_cfg_pkg::frame_t result;
	logic frame_ready;
	logic frame_take;

	line_sampler i_sampler (
		.pllclk(pllclk),
		.rst_n(rst_n),
		.lines(lines),
		.invert(invert),
		.sample(sample)
	);

	lag_correlator #(
		.INTEG_W(INTEG_W)
	) i_correlator (
		.pllclk(pllclk),
		.rst_n(rst_n),
		.sample(sample),
		.start(start),
		.integ_len(integ_len),
		.busy(busy),
		.frame_ready(frame_ready),
		.frame_take(frame_take),
		.result(result)
	);

	frame_packer #(
		.NUM_CREDITS(NUM_CREDITS)
	) i_packer (
		.pllclk(pllclk),
		.rst_n(rst_n),
		.frame_ready(frame_ready),
		.frame_take(frame_take),
		.result(result),
		.credit_return(credit_return),
		.out_word(out_word),
		.out_valid(out_valid)
	);

endmodule

`default_nettype wire

// ==== design/frame_packer.sv ====
// Frame packer with credit flow control
`default_nettype none

module frame_packer #(
	parameter int NUM_CREDITS = 4
) (
	input logic pllclk,
	input logic rst_n,
	input logic frame_ready,
	output logic frame_take,
	input corr_cfg_pkg::frame_t result,
	input logic credit_return,
	output corr_pkt_pkg::pkt_word_u out_word,
	output logic out_valid
);

	localparam int cred_w = $clog2(NUM_CREDITS + 1);
	localparam int pos_w = $clog2(corr_cfg_pkg::num_counts + 1);

	logic [cred_w-1:0] credits;
	logic active;
	logic [pos_w-1:0] pos; // Zero is the header, then count index plus one
	logic [pos_w-1:0] count_idx;
	logic [corr_pkt_pkg::seq_w-1:0] seq;
	logic emit;
	corr_cfg_pkg::frame_t snap;
	corr_pkt_pkg::pkt_word_u next_word;

	assign frame_take = frame_ready && !active;
	assign emit = active && credits != '0;
	assign count_idx = pos - 1'b1;

	always_comb begin
		next_word = '0;
		if (pos == '0) begin
			next_word.header.kind = corr_pkt_pkg::word_kind_header;
			next_word.header.seq = seq;
			next_word.header.line_count = 8'(corr_cfg_pkg::num_lines);
			next_word.header.lag_count = 8'(corr_cfg_pkg::num_lags);
			next_word.header.resolution = 8'(corr_cfg_pkg::count_w);
		end else begin
			next_word.count.kind = corr_pkt_pkg::word_kind_count;
			next_word.count.index = corr_pkt_pkg::index_w'(count_idx);
			next_word.count.value = snap.counts[count_idx];
		end
	end

	always_ff @(posedge pllclk) begin
		if (!rst_n) begin
			credits <= cred_w'(NUM_CREDITS);
			active <= 1'b0;
			pos <= '0;
			seq <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= emit;

			// A returned credit and a sent word in one cycle cancel out
			unique case ({credit_return, emit})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase

			if (frame_take) begin
				active <= 1'b1;
				pos <= '0;
			end else if (emit) begin
				if (pos == pos_w'(corr_cfg_pkg::num_counts)) begin
					active <= 1'b0; // Last count is out
					seq <= seq + 1'b1;
				end else begin
					pos <= pos + 1'b1;
				end
			end
		end
	end

	// Snapshot frees the correlator for the next frame
	always_ff @(posedge pllclk) begin
		if (frame_take)
			snap <= result;
		if (emit)
			out_word <= next_word;
	end

endmodule

`default_nettype wire

// ==== design/lag_correlator.sv ====
// Auto and cross correlator with two lags
`default_nettype none

module lag_correlator #(
	parameter int INTEG_W = 16
) (
	input logic pllclk,
	input logic rst_n,
	input corr_cfg_pkg::sample_t sample,
	input logic start,
	input logic [INTEG_W-1:0] integ_len,
	output logic busy,
	output logic frame_ready,
	input logic frame_take,
	output corr_cfg_pkg::frame_t result
);

	typedef enum logic [1:0] {
		st_idle,
		st_integ,
		st_ready
	} state_t;

	state_t state;
	logic [INTEG_W-1:0] remaining;
	logic [corr_cfg_pkg::num_lines-1:0] hist;
	logic [corr_cfg_pkg::num_counts-1:0] hit;
	logic clear;
	logic accumulate;

	assign clear = start && state == st_idle;
	assign accumulate = state == st_integ && sample.valid;

	assign busy = state == st_integ;
	assign frame_ready = state == st_ready;

	// Coincidence of each line with itself and with its previous sample
	for (genvar i = 0; i < corr_cfg_pkg::num_lines; i++) begin : g_auto
		localparam int base = i * corr_cfg_pkg::num_lags;

		assign hit[base] = sample.bits[i];
		assign hit[base + 1] = sample.bits[i] & hist[i];
	end

	// First line of a pair against the current and delayed second line
	for (genvar a = 0; a < corr_cfg_pkg::num_lines; a++) begin : g_first
		for (genvar b = a + 1; b < corr_cfg_pkg::num_lines; b++) begin : g_second
			localparam int pair = a * corr_cfg_pkg::num_lines - a * (a + 1) / 2 + b - a - 1;
			localparam int base = corr_cfg_pkg::num_lines * corr_cfg_pkg::num_lags +
				pair * corr_cfg_pkg::num_lags;

			assign hit[base] = sample.bits[a] & sample.bits[b];
			assign hit[base + 1] = sample.bits[a] & hist[b];
		end
	end

	always_ff @(posedge pllclk) begin
		if (!rst_n) begin
			state <= st_idle;
			remaining <= '0;
		end else begin
			unique case (state)
				st_idle: begin
					if (clear) begin
						state <= st_integ;
						remaining <= integ_len; // Must be nonzero
					end
				end
				st_integ: begin
					if (sample.valid) begin
						remaining <= remaining - 1'b1;
						if (remaining == INTEG_W'(1))
							state <= st_ready; // Last sample goes in at this edge
					end
				end
				st_ready: begin
					if (frame_take)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Result stays stable through st_ready until the packer has copied it
	always_ff @(posedge pllclk) begin
		if (clear) begin
			hist <= '0;
			result <= '0;
		end else if (accumulate) begin
			hist <= sample.bits;
			for (int k = 0; k < corr_cfg_pkg::num_counts; k++) begin
				if (hit[k] && result.counts[k] != '1)
					result.counts[k] <= result.counts[k] + 1'b1; // Saturates at full scale
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/line_sampler.sv ====
// Input line sampler
`default_nettype none

module line_sampler (
	input logic pllclk,
	input logic rst_n,
	input logic [corr_cfg_pkg::num_lines-1:0] lines,
	input logic [corr_cfg_pkg::num_lines-1:0] invert,
	output corr_cfg_pkg::sample_t sample
);

	logic [corr_cfg_pkg::num_lines-1:0] lines_q;
	logic valid_q;

	// Raw lines are captured once on pllclk
	always_ff @(posedge pllclk) begin
		lines_q <= lines;
	end

	always_ff @(posedge pllclk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b1; // Every cycle carries a sample once out of reset
		end
	end

	assign sample.valid = valid_q;
	assign sample.bits = lines_q ^ invert; // Per line polarity

endmodule

`default_nettype wire

// ==== tb.f ====
design/corr_cfg_pkg.sv
design/corr_pkt_pkg.sv
design/line_sampler.sv
design/lag_correlator.sv
design/frame_packer.sv
design/correlator_top.sv
verification/tb_correlator.sv

// ==== verification/tb_correlator.sv ====
// Correlator testbench
`default_nettype none

module tb_correlator;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_credits = 4;
	localparam int integ_w = 16;
	localparam int num_counts = 20;

	localparam int corr_idle = 0;
	localparam int corr_integ = 1;
	localparam int corr_ready = 2;

	logic pllclk;
	logic rst_n;
	logic [3:0] lines = '0;
	logic [3:0] invert;
	logic [integ_w-1:0] integ_len;
	logic start;
	logic credit_return = 1'b0;
	corr_pkt_pkg::pkt_word_u out_word;
	logic out_valid;
	logic busy;

	// Correlator model
	int m_state;
	int m_remaining;
	int m_counts[num_counts];
	logic [3:0] m_hist;
	logic [3:0] lines_prev; // Lines as the sampler registered them
	logic [3:0] cur;
	int pair;

	// Packer and receiver model
	logic pk_active;
	int snap_counts[num_counts];
	int word_pos; // Zero expects the header
	int seq_exp;
	int frames_received;
	int words_sent;
	int credits_returned;
	int credit_due[$];
	int cycle;
	logic give;
	int give_idx;
	logic hold_credits;

	// The stimulus process reads these one edge late
	int frames_seen;
	int words_seen;

	int starts_issued;

	correlator_top #(
		.NUM_CREDITS(num_credits),
		.INTEG_W(integ_w)
	) i_dut (
		.pllclk(pllclk),
		.rst_n(rst_n),
		.lines(lines),
		.invert(invert),
		.integ_len(integ_len),
		.start(start),
		.credit_return(credit_return),
		.out_word(out_word),
		.out_valid(out_valid),
		.busy(busy)
	);

	initial begin
		pllclk = 1'b0;
		forever #20 pllclk = ~pllclk;
	end

	task automatic check_value(input string what, input int expected, input int actual);
		if (expected != actual) begin
			$display("** Error at %0d ns: %s, expected %0d, got %0d", $time, what, expected,
				actual);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s (at %0d ns)", msg, $time);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_word(input corr_pkt_pkg::pkt_word_u w);
		if (word_pos == 0) begin
			if (!pk_active)
				report_failure("A word came out with no finished frame to send");
			check_value("header kind", 1, int'(w.header.kind));
			check_value("header sequence", seq_exp % 128, int'(w.header.seq));
			check_value("header line count", 4, int'(w.header.line_count));
			check_value("header lag count", 2, int'(w.header.lag_count));
			check_value("header resolution", 24, int'(w.header.resolution));
		end else begin
			check_value("count kind", 0, int'(w.count.kind));
			check_value("count index", word_pos - 1, int'(w.count.index));
			check_value("count value", snap_counts[word_pos - 1], int'(w.count.value));
		end
		if (word_pos == num_counts) begin
			word_pos = 0; // Frame complete
			pk_active = 1'b0;
			seq_exp++;
			frames_received++;
		end else begin
			word_pos++;
		end
	endtask

	// Model, receiver and random lines run on the rising edge
	always @(posedge pllclk) begin
		if (!rst_n) begin
			m_state = corr_idle;
			m_remaining = 0;
			m_hist = '0;
			pk_active = 1'b0;
			word_pos = 0;
			seq_exp = 0;
			frames_received = 0;
			words_sent = 0;
			credits_returned = 0;
			credit_due.delete();
			cycle = 0;
			give = 1'b0;
		end else begin
			if (out_valid) begin
				words_sent++;
				check_value("words sent within returned credits", 1,
					int'(words_sent <= num_credits + credits_returned));
				check_word(out_word);
				credit_due.push_back(cycle + int'($urandom_range(5, 0)));
			end
			if (credit_return)
				credits_returned++;
			check_value("busy", int'(m_state == corr_integ), int'(busy));

			cur = lines_prev ^ invert;
			case (m_state)
				corr_idle: begin
					if (start) begin
						m_state = corr_integ;
						m_remaining = int'(integ_len);
						m_hist = '0;
						for (int k = 0; k < num_counts; k++)
							m_counts[k] = 0;
					end
				end
				corr_integ: begin
					for (int i = 0; i < 4; i++) begin
						if (cur[i])
							m_counts[2 * i]++;
						if (cur[i] && m_hist[i])
							m_counts[2 * i + 1]++;
					end
					pair = 0;
					for (int a = 0; a < 4; a++) begin
						for (int b = a + 1; b < 4; b++) begin
							if (cur[a] && cur[b])
								m_counts[8 + 2 * pair]++;
							if (cur[a] && m_hist[b])
								m_counts[9 + 2 * pair]++; // Second line one sample late
							pair++;
						end
					end
					m_hist = cur;
					m_remaining--;
					if (m_remaining == 0)
						m_state = corr_ready;
				end
				corr_ready: begin
					if (!pk_active) begin
						snap_counts = m_counts; // Packer takes the frame
						pk_active = 1'b1;
						m_state = corr_idle;
					end
				end
			endcase

			// At most one credit goes back per cycle
			give = 1'b0;
			give_idx = 0;
			if (!hold_credits) begin
				for (int i = 0; i < credit_due.size(); i++) begin
					if (!give && credit_due[i] <= cycle) begin
						give = 1'b1;
						give_idx = i;
					end
				end
				if (give)
					credit_due.delete(give_idx);
			end
			cycle++;
		end
		credit_return <= give;
		lines_prev = lines;
		lines <= 4'($urandom);
		frames_seen <= frames_received;
		words_seen <= word_pos;
	end

	// Callers are at a rising edge
	task automatic issue_start();
		start <= 1'b1;
		@(posedge pllclk);
		start <= 1'b0;
	endtask

	task automatic run_frame(input int length);
		invert <= 4'($urandom);
		integ_len <= integ_w'(length);
		issue_start();
		starts_issued++;
	endtask

	task automatic wait_busy_low(input int limit);
		int waited;
		waited = 0;
		do begin
			@(posedge pllclk);
			waited++;
		end while (busy && waited < limit);
		if (busy)
			report_failure("Timed out waiting for the frame to finish integrating");
	endtask

	task automatic wait_frames_drained(input int limit);
		int waited;
		waited = 0;
		do begin
			@(posedge pllclk);
			waited++;
		end while (frames_seen != starts_issued && waited < limit);
		if (frames_seen != starts_issued)
			report_failure("Timed out waiting for all started frames to arrive");
	endtask

	initial begin
		int stalled;
		void'($urandom(21));
		rst_n = 1'b0;
		invert = '0;
		integ_len = integ_w'(1);
		start = 1'b0;
		hold_credits = 1'b0;
		starts_issued = 0;
		repeat (5) @(posedge pllclk);
		rst_n <= 1'b1;

		// Nothing leaves the DUT before the first start
		repeat (10) begin
			@(posedge pllclk);
			check_value("out_valid after reset", 0, int'(out_valid));
			check_value("busy after reset", 0, int'(busy));
		end

		for (int n = 0; n < 8; n++) begin
			run_frame(int'($urandom_range(40, 1)));
			wait_busy_low(60);
			wait_frames_drained(400);
		end

		// A start during integration is dropped
		run_frame(30);
		repeat (3) @(posedge pllclk);
		check_value("busy before the extra start", 1, int'(busy));
		issue_start();
		wait_busy_low(60);
		wait_frames_drained(400);

		// Second frame integrates while the first one is sent
		run_frame(20);
		wait_busy_low(60);
		run_frame(int'($urandom_range(8, 1)));
		@(posedge pllclk);
		check_value("busy on the second frame", 1, int'(busy));
		check_value("frames out while the second integrates", starts_issued - 2, frames_seen);
		wait_busy_low(60);
		wait_frames_drained(400);

		hold_credits <= 1'b1;
		run_frame(10);
		wait_busy_low(60);
		repeat (40) @(posedge pllclk);
		stalled = words_seen;
		check_value("frame stalled without credits", 1,
			int'(stalled <= num_credits && frames_seen < starts_issued));
		repeat (10) @(posedge pllclk);
		check_value("words while stalled", stalled, words_seen);
		hold_credits <= 1'b0;
		wait_frames_drained(400);

		// No further frame may follow the last one
		repeat (30) begin
			@(posedge pllclk);
			check_value("out_valid after the last frame", 0, int'(out_valid));
		end

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire
